//--- logic/dctPkg.sv
`default_nettype none

package dctPkg;

   typedef logic signed [31:0] sampleT;   // input sample, pass result, buffer word
   typedef logic signed [15:0] coefT;     // Q15 cosine coefficient
   typedef logic signed [34:0] accT;      // eight-term sum plus headroom
   typedef logic [6:0] bufAddrT;          // {bank, row, col}

   localparam int BlockDim = 8;           // samples per row / column
   localparam int BlockSize = 64;         // samples per block

   // bank select, top bit of bufAddrT
   localparam logic InBank = 1'b0;        // input block, later the output block
   localparam logic TempBank = 1'b1;      // row pass results

   typedef enum logic
   {
      RowPass,
      ColumnPass
   } passT;

   typedef enum logic [2:0]
   {
      Idle,
      Load,
      RowRun,
      ColumnRun,
      Stream
   } ctrlStateT;

endpackage

`default_nettype wire

//--- logic/bufferPort.sv
`default_nettype none

interface bufferPort import dctPkg::*; ();

   logic writeEn;
   bufAddrT writeAddr;
   sampleT writeData;
   bufAddrT readAddr;
   sampleT readData;    // valid one cycle after readAddr

   // side that issues reads and writes
   modport client
   (
      output writeEn,
      output writeAddr,
      output writeData,
      output readAddr,
      input readData
   );

   // side that serves them
   modport memory
   (
      input writeEn,
      input writeAddr,
      input writeData,
      input readAddr,
      output readData
   );

endinterface

`default_nettype wire

//--- logic/blockBuffer.sv
`default_nettype none

module blockBuffer import dctPkg::*;
(
   input logic clk,
   bufferPort.memory port
);

   // bank 0 input/output, bank 1 temp
   sampleT mem [2 * BlockSize];

   always_ff @(posedge clk)
   begin
      if (port.writeEn)
      begin
         mem[port.writeAddr] <= port.writeData;
      end
      port.readData <= mem[port.readAddr];   // registered read, one cycle latency
   end

endmodule

`default_nettype wire

//--- logic/cosineRom.sv
`default_nettype none

module cosineRom import dctPkg::*;
(
   input logic [2:0] freq,
   input logic [2:0] index,
   output coefT coef
);

   // 32768 * cos((2k+1) u pi / 16), first index u, second k
   // u = 0 row is the 1/sqrt(2) scaled DC term
   localparam coefT CosTable [BlockDim][BlockDim] = '{
      '{ 23170,  23170,  23170,  23170,  23170,  23170,  23170,  23170},
      '{ 32138,  27246,  18205,   6393,  -6393, -18205, -27246, -32138},
      '{ 30274,  12540, -12540, -30274, -30274, -12540,  12540,  30274},
      '{ 27246,  -6393, -32138, -18205,  18205,  32138,   6393, -27246},
      '{ 23170, -23170, -23170,  23170,  23170, -23170, -23170,  23170},
      '{ 18205, -32138,   6393,  27246, -27246,  -6393,  32138, -18205},
      '{ 12540, -30274,  30274, -12540, -12540,  30274, -30274,  12540},
      '{  6393, -18205,  27246, -32138,  32138, -27246,  18205,  -6393}
   };

   assign coef = CosTable[freq][index];   // pure lookup, same cycle as address

endmodule

`default_nettype wire

//--- logic/macEngine.sv
`default_nettype none

module macEngine import dctPkg::*;
#(
   parameter int ColumnShift = 10        // column product scale
)
(
   input logic clk,
   input logic reset,
   input logic runPass,
   input passT pass,
   output logic passDone,
   bufferPort.client mem,
   output logic [2:0] freq,
   output logic [2:0] index,
   input coefT coef
);

   localparam logic [8:0] LastStep = 9'(BlockDim * BlockSize - 1);
   localparam logic [2:0] LastTerm = 3'(BlockDim - 1);

   passT passQ;                  // pass latched at runPass
   logic running;                // stage 0 active
   logic [8:0] stepCnt;          // {outer, middle, sum index}
   logic [8:0] stepQ1;
   logic [8:0] stepQ2;
   logic [8:0] stepQ3;
   logic valid1;
   logic valid2;
   logic valid3;
   coefT coefQ;                  // coefficient aligned with readData
   sampleT prodQ;                // scaled product
   accT acc;
   logic signed [63:0] fullProd;
   logic signed [63:0] shiftedProd;
   logic [2:0] outerIdx;
   logic [2:0] middleIdx;
   logic [2:0] sumIdx;
   logic outBank;

   assign outerIdx = stepCnt[8:6];
   assign middleIdx = stepCnt[5:3];
   assign sumIdx = stepCnt[2:0];

   // stage 0: buffer address and coefficient lookup
   always_comb
   begin
      if (passQ == RowPass)
      begin
         mem.readAddr = {InBank, middleIdx, sumIdx};    // in(r, k)
         freq = outerIdx;                               // u
      end
      else
      begin
         mem.readAddr = {TempBank, sumIdx, outerIdx};   // temp(k, u)
         freq = middleIdx;                              // v
      end
   end

   assign index = sumIdx;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         passQ <= RowPass;
         running <= 1'b0;
         stepCnt <= '0;
         stepQ1 <= '0;
         stepQ2 <= '0;
         stepQ3 <= '0;
         valid1 <= 1'b0;
         valid2 <= 1'b0;
         valid3 <= 1'b0;
         passDone <= 1'b0;
      end
      else
      begin
         if (runPass)
         begin
            passQ <= pass;
            running <= 1'b1;
            stepCnt <= '0;
         end
         else if (running)
         begin
            stepCnt <= stepCnt + 9'd1;
            if (stepCnt == LastStep)
            begin
               running <= 1'b0;     // last address issued
            end
         end
         valid1 <= running;
         valid2 <= valid1;
         valid3 <= valid2;
         stepQ1 <= stepCnt;           // counter follows the data
         stepQ2 <= stepQ1;
         stepQ3 <= stepQ2;
         passDone <= valid3 && (stepQ3 == LastStep);   // after final write
      end
   end

   // stage 1: product, 64-bit signed then aligned per pass
   assign fullProd = mem.readData * coefQ;
   assign shiftedProd = fullProd >>> ColumnShift;

   always_ff @(posedge clk)
   begin
      if (running)
      begin
         coefQ <= coef;
      end
      if (valid1)
      begin
         if (passQ == RowPass)
         begin
            prodQ <= sampleT'(fullProd);       // low word, wraps
         end
         else
         begin
            prodQ <= sampleT'(shiftedProd);    // bits Shift+31 .. Shift
         end
      end
      // stage 2: restart the sum on the first term
      if (valid2)
      begin
         acc <= ((stepQ2[2:0] == 3'd0) ? accT'(0) : acc) + accT'(prodQ);
      end
   end

   // stage 3: sum complete when its eighth term has been added
   assign outBank = (passQ == RowPass) ? TempBank : InBank;
   assign mem.writeEn = valid3 && (stepQ3[2:0] == LastTerm);
   assign mem.writeAddr = {outBank, stepQ3[5:3], stepQ3[8:6]};
   assign mem.writeData = (passQ == RowPass) ? acc[31:0] : acc[33:2];   // divide by 4

endmodule

`default_nettype wire

//--- logic/dctControl.sv
`default_nettype none

module dctControl import dctPkg::*;
(
   input logic clk,
   input logic reset,
   input logic start,
   input sampleT din,
   output logic reading,
   output logic done,
   output sampleT dout,
   output logic runPass,
   output passT pass,
   input logic passDone,
   bufferPort.memory engine,
   bufferPort.client mem
);

   localparam logic [5:0] LastSample = 6'(BlockSize - 1);

   ctrlStateT state;
   logic [5:0] cnt;          // load / stream position, row-major
   logic readValid;          // readData holds a stream word
   logic engineOwns;

   assign engineOwns = (state == RowRun) || (state == ColumnRun);

   // buffer port owner switch
   always_comb
   begin
      if (engineOwns)
      begin
         mem.writeEn = engine.writeEn;
         mem.writeAddr = engine.writeAddr;
         mem.writeData = engine.writeData;
         mem.readAddr = engine.readAddr;
      end
      else
      begin
         mem.writeEn = (state == Load);      // capture din while reading
         mem.writeAddr = {InBank, cnt};
         mem.writeData = din;
         mem.readAddr = {InBank, cnt};       // stream reads, one ahead of dout
      end
   end

   assign engine.readData = mem.readData;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= Idle;
         cnt <= '0;
         reading <= 1'b0;
         done <= 1'b0;
         dout <= '0;
         runPass <= 1'b0;
         pass <= RowPass;
         readValid <= 1'b0;
      end
      else
      begin
         runPass <= 1'b0;                                  // single-cycle pulse
         done <= (state == Stream) && (cnt == 6'd0);      // lines up with first readData
         readValid <= (state == Stream);
         if (readValid)
         begin
            dout <= mem.readData;
         end
         case (state)
            Idle:
            begin
               if (start)
               begin
                  reading <= 1'b1;
                  cnt <= '0;
                  state <= Load;
               end
            end
            Load:
            begin
               cnt <= cnt + 6'd1;
               if (cnt == LastSample)
               begin
                  reading <= 1'b0;       // drops with the 64th sample
                  runPass <= 1'b1;
                  pass <= RowPass;
                  state <= RowRun;
               end
            end
            RowRun:
            begin
               if (passDone)
               begin
                  runPass <= 1'b1;
                  pass <= ColumnPass;
                  state <= ColumnRun;
               end
            end
            ColumnRun:
            begin
               if (passDone)
               begin
                  cnt <= '0;
                  state <= Stream;
               end
            end
            Stream:
            begin
               cnt <= cnt + 6'd1;
               if (cnt == LastSample)
               begin
                  state <= Idle;         // last word still in flight
               end
            end
            default:
            begin
               state <= Idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/dct2d.sv
`default_nettype none

module dct2d import dctPkg::*;
#(
   parameter int ColumnShift = 10       // column-pass product alignment
)
(
   input logic clk,
   input logic reset,
   input logic start,
   input sampleT din,
   output logic reading,
   output logic done,
   output sampleT dout
);

   logic runPass;
   passT pass;
   logic passDone;
   logic [2:0] freq;
   logic [2:0] index;
   coefT coef;

   bufferPort enginePort();    // engine to controller
   bufferPort memPort();       // controller to buffer

   blockBuffer buffer
   (
      .clk(clk),
      .port(memPort.memory)
   );

   cosineRom rom
   (
      .freq(freq),
      .index(index),
      .coef(coef)
   );

   macEngine #(.ColumnShift(ColumnShift)) engine
   (
      .clk(clk),
      .reset(reset),
      .runPass(runPass),
      .pass(pass),
      .passDone(passDone),
      .mem(enginePort.client),
      .freq(freq),
      .index(index),
      .coef(coef)
   );

   dctControl control
   (
      .clk(clk),
      .reset(reset),
      .start(start),
      .din(din),
      .reading(reading),
      .done(done),
      .dout(dout),
      .runPass(runPass),
      .pass(pass),
      .passDone(passDone),
      .engine(enginePort.memory),
      .mem(memPort.client)
   );

endmodule

`default_nettype wire

//--- tests/dctModel.sv
`default_nettype none

package dctModel;

   typedef int blockT [64];                      // row-major with n = 8 * row + col

   localparam int unsigned Seed = 32'ha36e;      // LCG start value
   localparam int ColShift = 10;                 // column product alignment in dct2d
   localparam real Pi = 3.14159265358979;

   // Q15 basis value with the DC row at 32768 / sqrt(2)
   function automatic int cosCoef(input int freq, input int index);
      real value;
      if (freq == 0)
      begin
         return 23170;
      end
      value = 32768.0 * $cos((2 * index + 1) * freq * Pi / 16.0);
      if (value >= 0.0)
      begin
         return $rtoi(value + 0.5);              // round to nearest
      end
      return -$rtoi(0.5 - value);
   endfunction

   // bit-exact two-pass reference
   function automatic void twoPassDct(input blockT src, output blockT dst);
      blockT tmp;
      longint sum;
      longint prod;
      // row pass keeps the low product word and wraps the sum to 32 bits
      for (int r = 0; r < 8; r++)
      begin
         for (int u = 0; u < 8; u++)
         begin
            sum = 0;
            for (int k = 0; k < 8; k++)
            begin
               prod = longint'(src[8 * r + k]) * cosCoef(u, k);
               sum += longint'(int'(prod));
            end
            tmp[8 * r + u] = int'(sum);
         end
      end
      // column pass takes product bits 10..41 and sum bits 2..33
      for (int v = 0; v < 8; v++)
      begin
         for (int u = 0; u < 8; u++)
         begin
            sum = 0;                             // eight 32-bit terms never leave 35 bits
            for (int k = 0; k < 8; k++)
            begin
               prod = longint'(tmp[8 * k + u]) * cosCoef(v, k);
               sum += longint'(int'(prod >>> ColShift));
            end
            dst[8 * v + u] = int'(sum >>> 2);    // divide by four
         end
      end
   endfunction

   // 32-bit LCG step
   function automatic int unsigned lcgNext(input int unsigned state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // signed 12-bit sample from the upper LCG bits
   function automatic int toSigned12(input int unsigned raw);
      logic signed [11:0] narrow;
      narrow = raw[27:16];
      return int'(narrow);                       // sign extended
   endfunction

endpackage

`default_nettype wire

//--- tests/dctTb.sv
`default_nettype none

module dctTb import dctPkg::*, dctModel::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WaitLimit = 4000;      // cycles, two passes take about 1040

   logic clk;
   logic reset;
   logic start;
   sampleT din;
   logic reading;
   logic done;
   sampleT dout;
   int unsigned randState;
   blockT stim;                          // block fed to the DUT
   blockT golden;                        // expected coefficients

   dct2d uut
   (
      .clk(clk),
      .reset(reset),
      .start(start),
      .din(din),
      .reading(reading),
      .done(done),
      .dout(dout)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #4 clk = ~clk;                  // 8 ns period
      end
   end

   task automatic checkValue(input string testName, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
      if (expected !== actual)
      begin
         $display("FAILED %s: expected %0d, actual %0d", testName, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic timeoutFail(input string what);
      $display("timed out after %0d cycles waiting for %s", WaitLimit, what);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
   endtask

   // returns 1 ns after the edge that raised reading
   task automatic waitForReading();
      int cycles;
      cycles = 0;
      while (reading !== 1'b1)
      begin
         if (cycles == WaitLimit)
         begin
            timeoutFail("reading to rise");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   task automatic waitForDone();
      int cycles;
      cycles = 0;
      while (done !== 1'b1)
      begin
         if (cycles == WaitLimit)
         begin
            timeoutFail("done");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   // one start pulse, then 64 samples while reading is high
   task automatic loadBlock(input string testName);
      start = 1'b1;
      waitForReading();
      start = 1'b0;
      for (int i = 0; i < BlockSize; i++)
      begin
         checkValue(testName, 1, reading);   // still taking samples
         din = stim[i];
         @(posedge clk);
         #1;
      end
      checkValue(testName, 0, reading);      // falls with the 64th sample
      din = '0;
   endtask

   // done cycle, then one coefficient per cycle
   task automatic checkStream(input string testName);
      waitForDone();
      for (int n = 0; n < BlockSize; n++)
      begin
         @(posedge clk);
         #1;
         checkValue(testName, 0, done);      // single-cycle pulse
         checkValue(testName, golden[n], dout);
      end
   endtask

   task automatic randomStim();
      for (int i = 0; i < BlockSize; i++)
      begin
         randState = lcgNext(randState);
         stim[i] = toSigned12(randState);
      end
   endtask

   task automatic resetTest();
      checkValue("reset", 0, reading);
      checkValue("reset", 0, done);
      checkValue("reset", 0, dout);
   endtask

   task automatic zeroTest();
      for (int i = 0; i < BlockSize; i++)
      begin
         stim[i] = 0;
         golden[i] = 0;                  // nothing in, nothing out
      end
      loadBlock("zeroBlock");
      checkStream("zeroBlock");
   endtask

   task automatic constantTest();
      for (int i = 0; i < BlockSize; i++)
      begin
         stim[i] = 100;
      end
      twoPassDct(stim, golden);
      loadBlock("constantBlock");
      checkStream("constantBlock");
   endtask

   task automatic randomTest();
      randomStim();
      twoPassDct(stim, golden);
      loadBlock("randomBlock");
      checkStream("randomBlock");
   endtask

   task automatic backToBackTest();
      randomStim();
      twoPassDct(stim, golden);
      loadBlock("backToBack first");
      start = 1'b1;                      // lands in RowRun, must be ignored
      @(posedge clk);
      #1;
      start = 1'b0;
      repeat (4)
      begin
         checkValue("backToBack ignored start", 0, reading);
         @(posedge clk);
         #1;
      end
      checkStream("backToBack first");
      repeat (8)
      begin
         checkValue("backToBack idle", 0, done);    // no second done
         checkValue("backToBack idle", 0, reading);
         @(posedge clk);
         #1;
      end
      randomStim();
      twoPassDct(stim, golden);
      loadBlock("backToBack second");
      checkStream("backToBack second");
   endtask

   initial
   begin
      reset = 1'b1;
      start = 1'b0;
      din = '0;
      randState = Seed;
      repeat (2) @(posedge clk);         // reset over two edges
      #1;
      reset = 1'b0;
      resetTest();
      zeroTest();
      constantTest();
      randomTest();
      backToBackTest();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
logic/dctPkg.sv
logic/bufferPort.sv
logic/blockBuffer.sv
logic/cosineRom.sv
logic/macEngine.sv
logic/dctControl.sv
logic/dct2d.sv
tests/dctModel.sv
tests/dctTb.sv
